// File: verilog/rv_pkg.sv
package rv_pkg;

   ////////////////////////////////////////
   // Instruction word
   ////////////////////////////////////////

   // One word with two ways of reading the upper fields
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;                                    // R, I, U, J and B fields
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s;                                    // Store offset split
   } instr_u;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

   // ALU operations
   localparam logic [3:0] ALU_ADD    = 4'd0;
   localparam logic [3:0] ALU_SUB    = 4'd1;  // Also the equality compare
   localparam logic [3:0] ALU_AND    = 4'd2;
   localparam logic [3:0] ALU_OR     = 4'd3;
   localparam logic [3:0] ALU_XOR    = 4'd4;
   localparam logic [3:0] ALU_SLT    = 4'd5;
   localparam logic [3:0] ALU_SLTU   = 4'd6;
   localparam logic [3:0] ALU_SLL    = 4'd7;
   localparam logic [3:0] ALU_SRL    = 4'd8;
   localparam logic [3:0] ALU_SRA    = 4'd9;
   localparam logic [3:0] ALU_PASS_B = 4'd10; // LUI

   // Next PC
   localparam logic [2:0] PC_PLUS_4 = 3'd0;
   localparam logic [2:0] PC_BRANCH = 3'd1;
   localparam logic [2:0] PC_JUMP   = 3'd2;
   localparam logic [2:0] PC_MTVEC  = 3'd3;
   localparam logic [2:0] PC_MEPC   = 3'd4;

   // Write-back source
   localparam logic [1:0] WB_ALU = 2'd0;
   localparam logic [1:0] WB_MEM = 2'd1;
   localparam logic [1:0] WB_PC4 = 2'd2;
   localparam logic [1:0] WB_CSR = 2'd3;

   // CSR access
   localparam logic [1:0] CSR_NONE  = 2'd0;
   localparam logic [1:0] CSR_WRITE = 2'd1;
   localparam logic [1:0] CSR_SET   = 2'd2;

   localparam logic [11:0] CSR_MTVEC  = 12'h305;
   localparam logic [11:0] CSR_MEPC   = 12'h341;
   localparam logic [11:0] CSR_MCAUSE = 12'h342;

   // Trap causes
   localparam logic [31:0] CAUSE_ILLEGAL = 32'd2;
   localparam logic [31:0] CAUSE_ECALL   = 32'd11;

endpackage

// File: verilog/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
   input  rv_pkg::instr_u instr_i,
   input  logic           cond_i,
   output logic [4:0]     rs1_o,
   output logic [4:0]     rs2_o,
   output logic [4:0]     rd_o,
   output logic [31:0]    imm_o,
   output logic [3:0]     alu_op_o,
   output logic           alu_a_pc_o,
   output logic           alu_b_imm_o,
   output logic [2:0]     pc_sel_o,
   output logic [1:0]     wb_sel_o,
   output logic           reg_we_o,
   output logic           mem_we_o,
   output logic           mem_re_o,
   output logic [1:0]     csr_op_o,
   output logic [11:0]    csr_addr_o,
   output logic           csr_src_imm_o,
   output logic           trap_o,
   output logic [31:0]    cause_o
);

   logic [6:0] opcode;
   logic [6:0] funct7;
   logic [2:0] funct3;
   logic       illegal;
   logic       is_ecall;

   assign opcode     = instr_i.r.opcode;
   assign funct7     = instr_i.r.funct7;
   assign funct3     = instr_i.r.funct3;
   assign rs1_o      = instr_i.r.rs1;
   assign rs2_o      = instr_i.r.rs2;
   assign rd_o       = instr_i.r.rd;
   assign csr_addr_o = {instr_i.r.funct7, instr_i.r.rs2};

   // Shared by OP and OP-IMM, alt selects SUB or SRA
   function automatic logic [3:0] alu_from_funct(input logic [2:0] f3, input logic alt);
      logic [3:0] op;
      case (f3)
         3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
         3'b001:  op = rv_pkg::ALU_SLL;
         3'b010:  op = rv_pkg::ALU_SLT;
         3'b011:  op = rv_pkg::ALU_SLTU;
         3'b100:  op = rv_pkg::ALU_XOR;
         3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
         3'b110:  op = rv_pkg::ALU_OR;
         default: op = rv_pkg::ALU_AND;
      endcase
      return op;
   endfunction

   ////////////////////////////////////////
   // Immediate
   ////////////////////////////////////////

   always_comb begin
      case (opcode)
         rv_pkg::OP_STORE:  imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
         rv_pkg::OP_BRANCH: imm_o = {{20{funct7[6]}}, rd_o[0], funct7[5:0], rd_o[4:1], 1'b0};
         rv_pkg::OP_LUI,
         rv_pkg::OP_AUIPC:  imm_o = {funct7, rs2_o, rs1_o, funct3, 12'd0};
         rv_pkg::OP_JAL:    imm_o = {{12{funct7[6]}}, rs1_o, funct3, rs2_o[0], funct7[5:0],
                                     rs2_o[4:1], 1'b0};
         rv_pkg::OP_SYSTEM: imm_o = {27'd0, rs1_o};   // zimm for the CSR immediate forms
         default:           imm_o = {{20{funct7[6]}}, funct7, rs2_o};
      endcase
   end

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////

   always_comb begin
      alu_op_o      = rv_pkg::ALU_ADD;
      alu_a_pc_o    = 1'b0;
      alu_b_imm_o   = 1'b0;
      pc_sel_o      = rv_pkg::PC_PLUS_4;
      wb_sel_o      = rv_pkg::WB_ALU;
      reg_we_o      = 1'b0;
      mem_we_o      = 1'b0;
      mem_re_o      = 1'b0;
      csr_op_o      = rv_pkg::CSR_NONE;
      csr_src_imm_o = 1'b0;
      illegal       = 1'b0;
      is_ecall      = 1'b0;
      case (opcode)
         rv_pkg::OP_LUI: begin
            alu_op_o    = rv_pkg::ALU_PASS_B;
            alu_b_imm_o = 1'b1;
            reg_we_o    = 1'b1;
         end
         rv_pkg::OP_AUIPC: begin
            alu_a_pc_o  = 1'b1;
            alu_b_imm_o = 1'b1;
            reg_we_o    = 1'b1;
         end
         rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
            alu_a_pc_o  = (opcode == rv_pkg::OP_JAL);  // JALR adds to rs1
            alu_b_imm_o = 1'b1;
            pc_sel_o    = rv_pkg::PC_JUMP;
            wb_sel_o    = rv_pkg::WB_PC4;
            reg_we_o    = 1'b1;
         end
         rv_pkg::OP_BRANCH: begin
            case (funct3[2:1])
               2'b00:   alu_op_o = rv_pkg::ALU_SUB;   // BEQ, BNE
               2'b10:   alu_op_o = rv_pkg::ALU_SLT;   // BLT, BGE
               2'b11:   alu_op_o = rv_pkg::ALU_SLTU;
               default: illegal  = 1'b1;
            endcase
            // funct3[0] flips the sense of the compare
            if (cond_i ^ funct3[0])
               pc_sel_o = rv_pkg::PC_BRANCH;
         end
         rv_pkg::OP_LOAD: begin
            illegal     = (funct3 != 3'b010);         // Words only
            alu_b_imm_o = 1'b1;
            mem_re_o    = !illegal;
            wb_sel_o    = rv_pkg::WB_MEM;
            reg_we_o    = !illegal;
         end
         rv_pkg::OP_STORE: begin
            illegal     = (funct3 != 3'b010);
            alu_b_imm_o = 1'b1;
            mem_we_o    = !illegal;
         end
         rv_pkg::OP_IMM: begin
            alu_op_o    = alu_from_funct(funct3, (funct3 == 3'b101) && funct7[5]);
            alu_b_imm_o = 1'b1;
            reg_we_o    = 1'b1;
         end
         rv_pkg::OP_REG: begin
            alu_op_o = alu_from_funct(funct3, funct7[5]);
            reg_we_o = 1'b1;
         end
         rv_pkg::OP_SYSTEM: begin
            case (funct3)
               3'b000: begin
                  if (csr_addr_o == 12'h000)
                     is_ecall = 1'b1;
                  else if (csr_addr_o == 12'h302)
                     pc_sel_o = rv_pkg::PC_MEPC;   // MRET
                  else
                     illegal = 1'b1;
               end
               3'b001, 3'b101: begin
                  csr_op_o      = rv_pkg::CSR_WRITE;
                  csr_src_imm_o = funct3[2];
                  wb_sel_o      = rv_pkg::WB_CSR;
                  reg_we_o      = 1'b1;
               end
               3'b010, 3'b110: begin
                  csr_op_o      = rv_pkg::CSR_SET;
                  csr_src_imm_o = funct3[2];
                  wb_sel_o      = rv_pkg::WB_CSR;
                  reg_we_o      = 1'b1;
               end
               default: illegal = 1'b1;
            endcase
         end
         default: illegal = 1'b1;
      endcase

      // Trap entry goes straight to the handler
      trap_o  = illegal | is_ecall;
      cause_o = is_ecall ? rv_pkg::CAUSE_ECALL : rv_pkg::CAUSE_ILLEGAL;
      if (trap_o)
         pc_sel_o = rv_pkg::PC_MTVEC;
   end

   always_comb begin
      assert final (!(trap_o && (reg_we_o || mem_we_o)))
         else $error("Trap with a register or memory write");
   end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  rs1_i,
   input  logic [4:0]  rs2_i,
   input  logic [4:0]  rd_i,
   input  logic [31:0] wdata_i,
   input  logic        we_i,
   output logic [31:0] rdata1_o,
   output logic [31:0] rdata2_o
);

   logic [31:0] regs [32];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (we_i && (rd_i != 5'd0)) begin   // x0 never written
         regs[rd_i] <= wdata_i;
      end
   end

   // Asynchronous reads
   assign rdata1_o = regs[rs1_i];
   assign rdata2_o = regs[rs2_i];

   // x0 must read zero on both ports
   a_x0_zero: assert property (@(posedge clk) disable iff (rst)
      ((rs1_i == 5'd0) |-> (rdata1_o == '0)) and ((rs2_i == 5'd0) |-> (rdata2_o == '0)))
      else $error("Register x0 read nonzero");

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
   input  logic [3:0]  op_i,
   input  logic [31:0] a_i,
   input  logic [31:0] b_i,
   output logic [31:0] result_o,
   output logic        cond_o
);

   logic [4:0]  shamt;
   logic        lt_signed;
   logic        lt_unsigned;
   logic [31:0] diff;

   assign shamt       = b_i[4:0];
   assign diff        = a_i - b_i;
   assign lt_signed   = $signed(a_i) < $signed(b_i);
   assign lt_unsigned = a_i < b_i;

   always_comb begin
      case (op_i)
         rv_pkg::ALU_ADD:    result_o = a_i + b_i;
         rv_pkg::ALU_SUB:    result_o = diff;
         rv_pkg::ALU_AND:    result_o = a_i & b_i;
         rv_pkg::ALU_OR:     result_o = a_i | b_i;
         rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
         rv_pkg::ALU_SLT:    result_o = {31'd0, lt_signed};
         rv_pkg::ALU_SLTU:   result_o = {31'd0, lt_unsigned};
         rv_pkg::ALU_SLL:    result_o = a_i << shamt;
         rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
         rv_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
         rv_pkg::ALU_PASS_B: result_o = b_i;
         default:            result_o = '0;
      endcase
   end

   ////////////////////////////////////////
   // Branch compare flag
   ////////////////////////////////////////

   // Decoder picks the compare through the operation code
   always_comb begin
      case (op_i)
         rv_pkg::ALU_SUB:  cond_o = (diff == '0);    // Equal
         rv_pkg::ALU_SLT:  cond_o = lt_signed;
         rv_pkg::ALU_SLTU: cond_o = lt_unsigned;
         default:          cond_o = 1'b0;
      endcase
   end

endmodule

// File: verilog/rv_csr.sv
`timescale 1ns/100ps

module rv_csr (
   input  logic        clk,
   input  logic        rst,
   input  logic [1:0]  op_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] wdata_i,
   output logic [31:0] rdata_o,
   input  logic [31:0] pc_i,
   input  logic        trap_i,
   input  logic [31:0] cause_i,
   output logic [31:0] mtvec_o,
   output logic [31:0] mepc_o
);

   logic [31:0] mtvec_q;
   logic [31:0] mepc_q;
   logic [31:0] mcause_q;
   logic [31:0] new_val;

   // Old value of the addressed CSR, unknown ones read zero
   always_comb begin
      case (addr_i)
         rv_pkg::CSR_MTVEC:  rdata_o = mtvec_q;
         rv_pkg::CSR_MEPC:   rdata_o = mepc_q;
         rv_pkg::CSR_MCAUSE: rdata_o = mcause_q;
         default:            rdata_o = '0;
      endcase
   end

   assign new_val = (op_i == rv_pkg::CSR_SET) ? (rdata_o | wdata_i) : wdata_i;

   ////////////////////////////////////////
   // Update
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         mtvec_q  <= '0;
         mepc_q   <= '0;
         mcause_q <= '0;
      end else if (trap_i) begin            // Trap entry wins
         mepc_q   <= pc_i;
         mcause_q <= cause_i;
      end else if (op_i != rv_pkg::CSR_NONE) begin
         case (addr_i)
            rv_pkg::CSR_MTVEC:  mtvec_q  <= new_val;
            rv_pkg::CSR_MEPC:   mepc_q   <= {new_val[31:2], 2'b00};
            rv_pkg::CSR_MCAUSE: mcause_q <= new_val;
            default: ;
         endcase
      end
   end

   assign mtvec_o = mtvec_q;
   assign mepc_o  = mepc_q;

   // Trapping PC from the core has to be word aligned
   a_mepc_aligned: assert property (@(posedge clk) disable iff (rst) mepc_q[1:0] == 2'b00)
      else $error("mepc not word aligned");

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/100ps

module rv_core (
   input  logic        clk,
   input  logic        rst,
   output logic [31:0] pc_o,
   input  logic [31:0] instr_i,
   output logic [31:0] dmem_addr_o,
   output logic [31:0] dmem_wdata_o,
   input  logic [31:0] dmem_rdata_i,
   output logic        dmem_we_o,
   output logic        dmem_re_o
);

   logic [31:0] pc_q, pc_next, pc_plus4;
   logic [4:0]  rs1, rs2, rd;
   logic [31:0] imm;
   logic [3:0]  alu_op;
   logic        alu_a_pc, alu_b_imm;
   logic [2:0]  pc_sel;
   logic [1:0]  wb_sel;
   logic        reg_we, mem_we, mem_re;
   logic [1:0]  csr_op;
   logic [11:0] csr_addr;
   logic        csr_src_imm;
   logic        trap;
   logic [31:0] cause;
   logic        cond;
   logic [31:0] rdata1, rdata2;
   logic [31:0] alu_a, alu_b, alu_result;
   logic [31:0] wb_data;
   logic [31:0] csr_wdata, csr_rdata;
   logic [31:0] mtvec, mepc;

   ////////////////////////////////////////
   // PC
   ////////////////////////////////////////

   assign pc_plus4 = pc_q + 32'd4;

   always_comb begin
      case (pc_sel)
         rv_pkg::PC_BRANCH: pc_next = pc_q + imm;
         rv_pkg::PC_JUMP:   pc_next = {alu_result[31:1], 1'b0};
         rv_pkg::PC_MTVEC:  pc_next = mtvec;
         rv_pkg::PC_MEPC:   pc_next = mepc;
         default:           pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         pc_q <= '0;
      else
         pc_q <= pc_next;
   end

   assign pc_o = pc_q;

   rv_decode decode_i (
      .instr_i(instr_i), .cond_i(cond),
      .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
      .alu_op_o(alu_op), .alu_a_pc_o(alu_a_pc), .alu_b_imm_o(alu_b_imm),
      .pc_sel_o(pc_sel), .wb_sel_o(wb_sel),
      .reg_we_o(reg_we), .mem_we_o(mem_we), .mem_re_o(mem_re),
      .csr_op_o(csr_op), .csr_addr_o(csr_addr), .csr_src_imm_o(csr_src_imm),
      .trap_o(trap), .cause_o(cause)
   );

   rv_regfile regfile_i (
      .clk(clk), .rst(rst), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
      .wdata_i(wb_data), .we_i(reg_we), .rdata1_o(rdata1), .rdata2_o(rdata2)
   );

   assign alu_a = alu_a_pc  ? pc_q : rdata1;
   assign alu_b = alu_b_imm ? imm  : rdata2;

   rv_alu alu_i (.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result), .cond_o(cond));

   assign csr_wdata = csr_src_imm ? imm : rdata1;

   rv_csr csr_i (
      .clk(clk), .rst(rst), .op_i(csr_op), .addr_i(csr_addr),
      .wdata_i(csr_wdata), .rdata_o(csr_rdata), .pc_i(pc_q),
      .trap_i(trap), .cause_i(cause), .mtvec_o(mtvec), .mepc_o(mepc)
   );

   // Write-back source
   always_comb begin
      case (wb_sel)
         rv_pkg::WB_MEM: wb_data = dmem_rdata_i;
         rv_pkg::WB_PC4: wb_data = pc_plus4;       // Link address
         rv_pkg::WB_CSR: wb_data = csr_rdata;
         default:        wb_data = alu_result;
      endcase
   end

   ////////////////////////////////////////
   // Data port
   ////////////////////////////////////////

   assign dmem_addr_o  = alu_result;
   assign dmem_wdata_o = rdata2;
   assign dmem_we_o    = mem_we & ~rst;   // Quiet during reset
   assign dmem_re_o    = mem_re & ~rst;

   a_no_rd_wr: assert property (@(posedge clk) !(dmem_we_o && dmem_re_o))
      else $error("Data read and write in the same cycle");

endmodule

// File: bench/tb_core.sv
`timescale 1ns/100ps

module tb_core;

   localparam int CLK_PERIOD = 10;
   localparam int MAX_CYCLES = 2000;   // All tests together run far below this
   localparam logic [31:0] FILL = 32'hC0DE0000;

   // {alt, funct3} for ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
   localparam logic [3:0] OP_TABLE [10] = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4,
                                            4'h2, 4'h3, 4'h1, 4'h5, 4'hD};

   logic        clk, rst, dmem_we, dmem_re;
   logic [31:0] pc, instr, dmem_addr, dmem_wdata, dmem_rdata;
   logic [31:0] imem [512];
   logic [31:0] dmem [256];
   logic [31:0] exp_q [$];              // Expected word per data address
   logic [31:0] end_addr;
   int          prog_len;

   rv_core dut_i (
      .clk(clk), .rst(rst), .pc_o(pc), .instr_i(instr),
      .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata),
      .dmem_we_o(dmem_we), .dmem_re_o(dmem_re)
   );

   assign instr      = imem[pc[10:2]];
   assign dmem_rdata = dmem[dmem_addr[9:2]];

   always @(posedge clk)
      if (dmem_we)
         dmem[dmem_addr[9:2]] <= dmem_wdata;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(MAX_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Checks failed");
      $fatal(1, "Timeout");
   end

   ////////////////////////////////////////
   // Encoders
   ////////////////////////////////////////

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
      rv_pkg::instr_u w;
      w.r.funct7 = f7;
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
      w.r.opcode = op;
      return w;
   endfunction

   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
      return enc_r(imm[11:5], imm[4:0], rs1, f3, rd, op);   // Also CSR address
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      rv_pkg::instr_u w;
      w.s.imm_hi = imm[11:5];
      w.s.rs2    = rs2;
      w.s.rs1    = rs1;
      w.s.funct3 = 3'b010;
      w.s.imm_lo = imm[4:0];
      w.s.opcode = rv_pkg::OP_STORE;
      return w;
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [2:0] f3);
      rv_pkg::instr_u w;
      w.s.imm_hi = {off[12], off[10:5]};
      w.s.rs2    = rs2;
      w.s.rs1    = rs1;
      w.s.funct3 = f3;
      w.s.imm_lo = {off[4:1], off[11]};
      w.s.opcode = rv_pkg::OP_BRANCH;
      return w;
   endfunction

   function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'd0, $signed(a) < $signed(b)};
         3'd3:    return {31'd0, a < b};
         3'd4:    return a ^ b;
         3'd5: begin
            if (alt)
               return $signed(a) >>> b[4:0];
            else
               return a >> b[4:0];
         end
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         default: return $signed(a) >= $signed(b);
      endcase
   endfunction

   // {write, read} strobes of the data port for one fetched word
   function automatic logic [1:0] data_strobes(logic [31:0] w);
      logic word;
      word = (w[14:12] == 3'b010);
      return {(w[6:0] == rv_pkg::OP_STORE) && word, (w[6:0] == rv_pkg::OP_LOAD) && word};
   endfunction

   function automatic logic [31:0] here();
      return 32'(prog_len * 4);
   endfunction

   ////////////////////////////////////////
   // Program handling and checks
   ////////////////////////////////////////

   task automatic put(logic [31:0] w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic load_const(logic [4:0] rd, logic [31:0] v);
      logic [31:0] upper;
      upper = (v + 32'h800) >> 12;   // ADDI sign extends the low part
      put(enc_u(upper[19:0], rd, rv_pkg::OP_LUI));
      put(enc_i(v[11:0], rd, 3'd0, rd, rv_pkg::OP_IMM));
   endtask

   // Next free data word gets register rs2
   task automatic store_exp(logic [4:0] rs2, logic [31:0] exp);
      put(enc_s(12'(exp_q.size() * 4), rs2, 5'd0));
      exp_q.push_back(exp);
   endtask

   task automatic put_end;
      end_addr = here();
      put(enc_j(21'd0, 5'd0));   // Spin in place
   endtask

   task automatic clear_memories;
      for (int i = 0; i < 512; i++)
         imem[i] = 32'h0;
      for (int i = 0; i < 256; i++)
         dmem[i] <= FILL | 32'(i);
      prog_len = 0;
      exp_q.delete();
   endtask

   task automatic start_program;
      @(posedge clk);
      #1 rst = 1'b1;
      clear_memories();
   endtask

   task automatic run_program;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      do
         @(negedge clk);
      while (pc != end_addr);
   endtask

   task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s expected %h actual %h", name, exp, act);
         $display("Checks failed");
         $fatal(1, "Stopping on first mismatch");
      end
   endtask

   task automatic check_stores(string name);
      foreach (exp_q[k])
         check_value(name, exp_q[k], dmem[k]);
   endtask

   // Data port strobes, quiet in reset and following the fetched word otherwise
   always @(negedge clk) begin
      if (rst)
         check_value("reset_strobes", 32'd0, {30'd0, dmem_we, dmem_re});
      else
         check_value("data_strobes", {30'd0, data_strobes(instr)}, {30'd0, dmem_we, dmem_re});
   end

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic alu_test(string name, int n, bit rnd);
      logic [31:0] a, b;
      int          sel;
      start_program();
      for (int k = 0; k < n; k++) begin
         a   = rnd ? $urandom : 32'h87654321;
         b   = rnd ? $urandom : 32'h00000ABC;
         sel = rnd ? int'($urandom_range(9, 0)) : k % 10;
         load_const(5'd1, a);
         load_const(5'd2, b);
         put(enc_r({1'b0, OP_TABLE[sel][3], 5'd0}, 5'd2, 5'd1, OP_TABLE[sel][2:0], 5'd3,
                   rv_pkg::OP_REG));
         store_exp(5'd3, ref_alu(OP_TABLE[sel][2:0], OP_TABLE[sel][3], a, b));
      end
      put_end();
      run_program();
      check_stores(name);
   endtask

   task automatic mem_test;
      start_program();
      put(enc_i(12'h055, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
      put(enc_s(12'h040, 5'd1, 5'd0));
      put(enc_i(12'h040, 5'd0, 3'b010, 5'd2, rv_pkg::OP_LOAD));
      put(enc_i(12'h001, 5'd2, 3'd0, 5'd2, rv_pkg::OP_IMM));
      put(enc_i(12'h007, 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM));   // Write to x0
      store_exp(5'd2, 32'h56);
      store_exp(5'd0, 32'h0);
      put_end();
      run_program();
      check_stores("mem");
      check_value("mem_first_store", 32'h55, dmem[16]);
   endtask

   // Taken branch skips the marker store, leaving the fill word
   task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                              logic [31:0] a, logic [31:0] b);
      int idx;
      idx = exp_q.size();
      put(enc_b(13'd12, rs1, rs2, f3));
      put(enc_i(12'(32'h100 + idx), 5'd0, 3'd0, 5'd3, rv_pkg::OP_IMM));
      store_exp(5'd3, branch_taken(f3, a, b) ? (FILL | 32'(idx)) : 32'h100 + 32'(idx));
   endtask

   task automatic control_test;
      logic [31:0] p;
      start_program();
      put(enc_i(12'h001, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
      put(enc_i(12'hFFE, 5'd0, 3'd0, 5'd2, rv_pkg::OP_IMM));   // x2 = -2
      branch_case(3'd0, 5'd1, 5'd2, 32'd1, -32'd2);
      branch_case(3'd0, 5'd1, 5'd1, 32'd1, 32'd1);
      branch_case(3'd1, 5'd1, 5'd2, 32'd1, -32'd2);
      branch_case(3'd1, 5'd1, 5'd1, 32'd1, 32'd1);
      branch_case(3'd4, 5'd2, 5'd1, -32'd2, 32'd1);
      branch_case(3'd4, 5'd1, 5'd2, 32'd1, -32'd2);
      branch_case(3'd5, 5'd1, 5'd2, 32'd1, -32'd2);
      branch_case(3'd5, 5'd2, 5'd1, -32'd2, 32'd1);
      p = here();
      put(enc_j(21'd8, 5'd5));
      put(enc_i(12'h077, 5'd0, 3'd0, 5'd5, rv_pkg::OP_IMM));  // Skipped
      store_exp(5'd5, p + 32'd4);
      p = here() + 32'd12;                                     // JALR target
      put(enc_i(p[11:0], 5'd0, 3'd0, 5'd6, rv_pkg::OP_IMM));
      put(enc_i(12'h000, 5'd6, 3'd0, 5'd7, rv_pkg::OP_JALR));
      put(enc_i(12'h099, 5'd0, 3'd0, 5'd8, rv_pkg::OP_IMM));  // Skipped
      store_exp(5'd7, p - 32'd4);
      store_exp(5'd8, 32'h0);
      p = here();
      put(enc_u(20'h00001, 5'd9, rv_pkg::OP_AUIPC));
      store_exp(5'd9, p + 32'h1000);
      put_end();
      run_program();
      check_stores("control");
   endtask

   task automatic csr_test;
      start_program();
      put(enc_i(12'h100, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
      put(enc_i(rv_pkg::CSR_MTVEC, 5'd1, 3'b001, 5'd2, rv_pkg::OP_SYSTEM));
      put(enc_i(rv_pkg::CSR_MTVEC, 5'd0, 3'b010, 5'd3, rv_pkg::OP_SYSTEM));
      put(enc_i(12'h005, 5'd0, 3'd0, 5'd4, rv_pkg::OP_IMM));
      put(enc_i(rv_pkg::CSR_MCAUSE, 5'd4, 3'b010, 5'd5, rv_pkg::OP_SYSTEM));
      put(enc_i(rv_pkg::CSR_MCAUSE, 5'd0, 3'b010, 5'd6, rv_pkg::OP_SYSTEM));
      store_exp(5'd2, 32'h0);
      store_exp(5'd3, 32'h100);
      store_exp(5'd5, 32'h0);
      store_exp(5'd6, 32'h5);
      put_end();
      run_program();
      check_stores("csr");
   endtask

   task automatic trap_test;
      start_program();
      put(enc_i(12'h200, 5'd0, 3'd0, 5'd1, rv_pkg::OP_IMM));
      put(enc_i(rv_pkg::CSR_MTVEC, 5'd1, 3'b001, 5'd0, rv_pkg::OP_SYSTEM));
      exp_q.push_back(rv_pkg::CAUSE_ECALL);
      exp_q.push_back(here());
      put(32'h00000073);                                       // ECALL
      exp_q.push_back(rv_pkg::CAUSE_ILLEGAL);
      exp_q.push_back(here());
      put(32'hFFFFFFFF);                                       // Unknown opcode
      put(enc_i(12'h033, 5'd0, 3'd0, 5'd4, rv_pkg::OP_IMM));
      store_exp(5'd4, 32'h33);                                 // Resumed after both
      put_end();
      // Handler at 0x200 logs mcause and mepc through x10
      prog_len = 128;
      put(enc_i(rv_pkg::CSR_MCAUSE, 5'd0, 3'b010, 5'd2, rv_pkg::OP_SYSTEM));
      put(enc_i(rv_pkg::CSR_MEPC, 5'd0, 3'b010, 5'd3, rv_pkg::OP_SYSTEM));
      put(enc_s(12'h000, 5'd2, 5'd10));
      put(enc_s(12'h004, 5'd3, 5'd10));
      put(enc_i(12'h008, 5'd10, 3'd0, 5'd10, rv_pkg::OP_IMM));
      put(enc_i(12'h004, 5'd3, 3'd0, 5'd3, rv_pkg::OP_IMM));
      put(enc_i(rv_pkg::CSR_MEPC, 5'd3, 3'b001, 5'd0, rv_pkg::OP_SYSTEM));
      put(32'h30200073);                                       // MRET
      run_program();
      check_stores("trap");
   endtask

   initial begin
      rst = 1'b1;
      void'($urandom(13));
      clear_memories();
      alu_test("alu", 10, 1'b0);
      mem_test();
      control_test();
      csr_test();
      trap_test();
      alu_test("random_alu", 40, 1'b1);
      $display("All checks passed");
      $finish;
   end

endmodule

// File: sim.f
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_csr.sv
verilog/rv_core.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_core -o tb_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_core 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
   exit 0
fi
exit 1
